//--- verilog/if_macros.svh
// Instruction fetch widths and sizes
// Shared by the fetch packages and the prefetch FIFO

`ifndef IF_MACROS_SVH
`define IF_MACROS_SVH

// Byte address width
`define IF_ADDR_W       32

// Full instruction word and compressed parcel
`define IF_INSTR_W      32
`define IF_PARCEL_W     16

// Trap base forms address bits 31..8
`define IF_TRAP_BASE_W  24

// Interrupt cause for vectored entry
`define IF_CAUSE_W      5

// Prefetch FIFO depth in words
`define IF_FIFO_DEPTH   2

`endif

//--- verilog/if_addr_pkg.sv
// Address side types of the fetch stage
// Byte addresses, trap vector fields and the redirect source select

`include "if_macros.svh"

package if_addr_pkg;

        typedef logic [`IF_ADDR_W-1:0]      addr_t;
        typedef logic [`IF_TRAP_BASE_W-1:0] trap_base_t;
        typedef logic [`IF_CAUSE_W-1:0]     cause_t;

        // Redirect source, valid while pc_set_i is high
        typedef enum logic [2:0] {
                PC_BOOT,
                PC_JUMP,
                PC_EXC,
                PC_MRET,
                PC_DRET
        } pc_src_e;

        // Trap vector mode, as in mtvec
        typedef enum logic {
                EXC_DIRECT,
                EXC_VECTORED
        } exc_mode_e;

endpackage

//--- verilog/if_instr_pkg.sv
// Instruction side types of the fetch stage
// FIFO entries and the record handed to decode

`include "if_macros.svh"

package if_instr_pkg;

        typedef logic [`IF_INSTR_W-1:0]  instr_t;
        typedef logic [`IF_PARCEL_W-1:0] parcel_t;

        // One fetched word with its word address
        typedef struct packed {
                instr_t              instr;
                if_addr_pkg::addr_t  addr;
                logic                err;
        } fetch_entry_t;

        // Compressed parcels arrive zero-extended in instr
        typedef struct packed {
                instr_t              instr;
                if_addr_pkg::addr_t  pc;
                logic                is_compressed;
                logic                fetch_err;
        } id_out_t;

endpackage

//--- verilog/pc_select.sv
// Next-PC selection for the fetch stage
// Forces a boot redirect and the mtvec init pulse right after reset,
// otherwise follows pc_set_i with the source picked by pc_mux_i

`timescale 1ns/1ps
`include "if_macros.svh"

module pc_select (
        input  logic                    clk,
        input  logic                    rst_i,
        input  logic                    pc_set_i,
        input  if_addr_pkg::pc_src_e    pc_mux_i,
        input  if_addr_pkg::exc_mode_e  exc_mode_i,
        input  if_addr_pkg::addr_t      boot_addr_i,
        input  if_addr_pkg::addr_t      jump_target_i,
        input  if_addr_pkg::addr_t      mepc_i,
        input  if_addr_pkg::addr_t      depc_i,
        input  if_addr_pkg::trap_base_t trap_base_i,
        input  if_addr_pkg::cause_t     irq_cause_i,
        input  logic                    is_irq_i,
        output logic                    redirect_o,
        output if_addr_pkg::addr_t      redirect_addr_o,
        output logic                    csr_mtvec_init_o
);

        logic               rst_q;
        logic               boot;
        if_addr_pkg::addr_t exc_addr;
        if_addr_pkg::addr_t sel_addr;

        // High for the cycle after the last reset edge
        always_ff @(posedge clk) begin
                rst_q <= rst_i;
        end

        assign boot = rst_q & ~rst_i;

        // Base with the low byte cleared, plus 4 * cause for vectored irqs
        always_comb begin
                exc_addr = {trap_base_i, {(`IF_ADDR_W - `IF_TRAP_BASE_W){1'b0}}};
                if (exc_mode_i == if_addr_pkg::EXC_VECTORED && is_irq_i) begin
                        exc_addr = exc_addr + if_addr_pkg::addr_t'({irq_cause_i, 2'b00});
                end
        end

        always_comb begin
                case (pc_mux_i)
                        if_addr_pkg::PC_JUMP: sel_addr = jump_target_i;
                        if_addr_pkg::PC_EXC:  sel_addr = exc_addr;
                        if_addr_pkg::PC_MRET: sel_addr = mepc_i;
                        if_addr_pkg::PC_DRET: sel_addr = depc_i;
                        default:              sel_addr = boot_addr_i;
                endcase
                if (boot) begin
                        sel_addr = boot_addr_i;
                end
        end

        assign redirect_o       = boot | pc_set_i;
        assign redirect_addr_o  = {sel_addr[`IF_ADDR_W-1:1], 1'b0};
        assign csr_mtvec_init_o = boot;

endmodule

//--- verilog/prefetch_fifo.sv
// Prefetch FIFO with a read-only Wishbone classic master
// Fetches words in order while a slot is free, flushes on a redirect

`timescale 1ns/1ps
`include "if_macros.svh"

module prefetch_fifo (
        input  logic                       clk,
        input  logic                       rst_i,
        input  logic                       redirect_i,
        input  if_addr_pkg::addr_t         redirect_addr_i,
        output logic                       wb_cyc_o,
        output logic                       wb_stb_o,
        output if_addr_pkg::addr_t         wb_adr_o,
        input  if_instr_pkg::instr_t       wb_dat_i,
        input  logic                       wb_ack_i,
        input  logic                       wb_err_i,
        output logic                       fetch_valid_o,
        output if_instr_pkg::fetch_entry_t fetch_o,
        input  logic                       fetch_ready_i,
        output logic                       busy_o
);

        localparam int PTR_W = $clog2(`IF_FIFO_DEPTH);

        if_instr_pkg::fetch_entry_t mem [`IF_FIFO_DEPTH];
        logic [PTR_W-1:0]           rd_ptr_q;
        logic [PTR_W-1:0]           wr_ptr_q;
        logic [PTR_W:0]             count_q;
        logic                       cyc_q;
        logic                       discard_q;
        if_addr_pkg::addr_t         adr_q;
        if_addr_pkg::addr_t         next_q;
        if_addr_pkg::addr_t         redir_word;
        logic                       bus_done;
        logic                       push;
        logic                       pop;

        assign redir_word = {redirect_addr_i[`IF_ADDR_W-1:2], 2'b00};
        assign bus_done   = cyc_q & (wb_ack_i | wb_err_i);

        // A redirect wins over both sides of the FIFO
        assign push = bus_done & ~discard_q & ~redirect_i;
        assign pop  = fetch_valid_o & fetch_ready_i & ~redirect_i;

        // --------------------
        // Bus master
        // --------------------
        always_ff @(posedge clk) begin
                if (rst_i) begin
                        cyc_q     <= 1'b0;
                        discard_q <= 1'b0;
                end else if (redirect_i) begin
                        if (!cyc_q || bus_done) begin
                                // Bus is free, start at the new word right away
                                cyc_q     <= 1'b1;
                                discard_q <= 1'b0;
                        end else begin
                                // Let the open cycle finish and drop its data
                                discard_q <= 1'b1;
                        end
                end else if (bus_done) begin
                        cyc_q     <= 1'b0;
                        discard_q <= 1'b0;
                end else if (!cyc_q && count_q < `IF_FIFO_DEPTH) begin
                        cyc_q <= 1'b1;
                end
        end

        // Fetch addresses
        always_ff @(posedge clk) begin
                if (redirect_i) begin
                        if (!cyc_q || bus_done) begin
                                adr_q  <= redir_word;
                                next_q <= redir_word + 'd4;
                        end else begin
                                next_q <= redir_word;
                        end
                end else if (!cyc_q && count_q < `IF_FIFO_DEPTH) begin
                        adr_q  <= next_q;
                        next_q <= next_q + 'd4;
                end
        end

        assign wb_cyc_o = cyc_q;
        assign wb_stb_o = cyc_q;
        assign wb_adr_o = adr_q;

        // --------------------
        // Word FIFO
        // --------------------
        always_ff @(posedge clk) begin
                if (rst_i || redirect_i) begin
                        rd_ptr_q <= '0;
                        wr_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (push) begin
                                wr_ptr_q <= wr_ptr_q + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr_q <= rd_ptr_q + 1'b1;
                        end
                        count_q <= count_q + push - pop;
                end
        end

        // Error responses are kept and flagged, fetching goes on
        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr_q] <= '{instr: wb_dat_i, addr: adr_q, err: wb_err_i};
                end
        end

        assign fetch_valid_o = (count_q != '0);
        assign fetch_o       = mem[rd_ptr_q];
        assign busy_o        = cyc_q | fetch_valid_o;

endmodule

//--- verilog/fetch_aligner.sv
// Instruction aligner and decode output register
// Splits fetched words into 16 and 32 bit instructions, joins
// instructions that straddle two words, and tracks the PC

`timescale 1ns/1ps
`include "if_macros.svh"

module fetch_aligner (
        input  logic                       clk,
        input  logic                       rst_i,
        input  logic                       redirect_i,
        input  if_addr_pkg::addr_t         redirect_addr_i,
        input  logic                       fetch_valid_i,
        input  if_instr_pkg::fetch_entry_t fetch_i,
        output logic                       fetch_ready_o,
        output logic                       id_valid_o,
        output if_instr_pkg::id_out_t      id_o,
        input  logic                       id_ready_i
);

        logic                  hi_pending_q;
        logic                  skip_lo_q;
        if_instr_pkg::parcel_t hi_q;
        logic                  hi_err_q;
        if_addr_pkg::addr_t    pc_q;
        logic                  valid_q;
        if_instr_pkg::id_out_t out_q;
        if_instr_pkg::parcel_t lo;
        logic                  hi_c;
        logic                  lo_c;
        logic                  out_free;
        logic                  emit;
        logic                  load;
        logic                  fire;
        if_instr_pkg::id_out_t cand;

        assign lo   = fetch_i.instr[`IF_PARCEL_W-1:0];
        assign hi_c = (hi_q[1:0] != 2'b11);
        assign lo_c = (lo[1:0] != 2'b11);

        assign out_free = ~valid_q | id_ready_i;

        // A held compressed upper half needs no new word
        assign emit = hi_pending_q ? (hi_c | fetch_valid_i) : (fetch_valid_i & ~skip_lo_q);
        assign load = emit & out_free & ~redirect_i;

        assign fetch_ready_o = ~redirect_i &
                               ((~hi_pending_q & skip_lo_q) | ((~hi_pending_q | ~hi_c) & out_free));
        assign fire = fetch_valid_i & fetch_ready_o;

        // --------------------
        // Candidate instruction
        // --------------------
        always_comb begin
                cand    = '0;
                cand.pc = pc_q;
                if (hi_pending_q) begin
                        if (hi_c) begin
                                cand.instr         = if_instr_pkg::instr_t'(hi_q);
                                cand.is_compressed = 1'b1;
                                cand.fetch_err     = hi_err_q;
                        end else begin
                                // Straddling word, both halves count for the error
                                cand.instr     = {lo, hi_q};
                                cand.fetch_err = hi_err_q | fetch_i.err;
                        end
                end else begin
                        cand.fetch_err = fetch_i.err;
                        if (lo_c) begin
                                cand.instr         = if_instr_pkg::instr_t'(lo);
                                cand.is_compressed = 1'b1;
                        end else begin
                                cand.instr = fetch_i.instr;
                        end
                end
        end

        // --------------------
        // Control and PC
        // --------------------
        always_ff @(posedge clk) begin
                if (rst_i) begin
                        valid_q      <= 1'b0;
                        hi_pending_q <= 1'b0;
                        skip_lo_q    <= 1'b0;
                end else if (redirect_i) begin
                        valid_q      <= 1'b0;
                        hi_pending_q <= 1'b0;
                        skip_lo_q    <= redirect_addr_i[1];
                end else begin
                        if (out_free) begin
                                valid_q <= emit;
                        end
                        // Upper half stays held unless the lower half was a full instr
                        if (fire) begin
                                hi_pending_q <= skip_lo_q | hi_pending_q | lo_c;
                                skip_lo_q    <= 1'b0;
                        end else if (load) begin
                                hi_pending_q <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (redirect_i) begin
                        pc_q <= redirect_addr_i;
                end else if (load) begin
                        pc_q <= pc_q + (cand.is_compressed ? 'd2 : 'd4);
                end
                if (fire) begin
                        hi_q     <= fetch_i.instr[`IF_INSTR_W-1:`IF_PARCEL_W];
                        hi_err_q <= fetch_i.err;
                end
                if (load) begin
                        out_q <= cand;
                end
        end

        assign id_valid_o = valid_q;
        assign id_o       = out_q;

endmodule

//--- verilog/if_stage.sv
// Instruction fetch stage top level
// PC select, Wishbone prefetch FIFO and aligner towards decode

`timescale 1ns/1ps

module if_stage (
        input  logic                    clk,
        input  logic                    rst_i,
        input  logic                    pc_set_i,
        input  if_addr_pkg::pc_src_e    pc_mux_i,
        input  if_addr_pkg::exc_mode_e  exc_mode_i,
        input  if_addr_pkg::addr_t      boot_addr_i,
        input  if_addr_pkg::addr_t      jump_target_i,
        input  if_addr_pkg::addr_t      mepc_i,
        input  if_addr_pkg::addr_t      depc_i,
        input  if_addr_pkg::trap_base_t trap_base_i,
        input  if_addr_pkg::cause_t     irq_cause_i,
        input  logic                    is_irq_i,
        output logic                    csr_mtvec_init_o,
        output logic                    wb_cyc_o,
        output logic                    wb_stb_o,
        output if_addr_pkg::addr_t      wb_adr_o,
        input  if_instr_pkg::instr_t    wb_dat_i,
        input  logic                    wb_ack_i,
        input  logic                    wb_err_i,
        output logic                    id_valid_o,
        output if_instr_pkg::id_out_t   id_o,
        input  logic                    id_ready_i,
        output logic                    if_busy_o
);

        logic                       redirect;
        if_addr_pkg::addr_t         redirect_addr;
        logic                       fetch_valid;
        if_instr_pkg::fetch_entry_t fetch_entry;
        logic                       fetch_ready;

        pc_select i_pc_select (
                .clk              (clk),
                .rst_i            (rst_i),
                .pc_set_i         (pc_set_i),
                .pc_mux_i         (pc_mux_i),
                .exc_mode_i       (exc_mode_i),
                .boot_addr_i      (boot_addr_i),
                .jump_target_i    (jump_target_i),
                .mepc_i           (mepc_i),
                .depc_i           (depc_i),
                .trap_base_i      (trap_base_i),
                .irq_cause_i      (irq_cause_i),
                .is_irq_i         (is_irq_i),
                .redirect_o       (redirect),
                .redirect_addr_o  (redirect_addr),
                .csr_mtvec_init_o (csr_mtvec_init_o)
        );

        prefetch_fifo i_prefetch_fifo (
                .clk             (clk),
                .rst_i           (rst_i),
                .redirect_i      (redirect),
                .redirect_addr_i (redirect_addr),
                .wb_cyc_o        (wb_cyc_o),
                .wb_stb_o        (wb_stb_o),
                .wb_adr_o        (wb_adr_o),
                .wb_dat_i        (wb_dat_i),
                .wb_ack_i        (wb_ack_i),
                .wb_err_i        (wb_err_i),
                .fetch_valid_o   (fetch_valid),
                .fetch_o         (fetch_entry),
                .fetch_ready_i   (fetch_ready),
                .busy_o          (if_busy_o)
        );

        fetch_aligner i_fetch_aligner (
                .clk             (clk),
                .rst_i           (rst_i),
                .redirect_i      (redirect),
                .redirect_addr_i (redirect_addr),
                .fetch_valid_i   (fetch_valid),
                .fetch_i         (fetch_entry),
                .fetch_ready_o   (fetch_ready),
                .id_valid_o      (id_valid_o),
                .id_o            (id_o),
                .id_ready_i      (id_ready_i)
        );

endmodule

//--- tests/if_stage_sva.sv
// Protocol checks for the instruction fetch stage
// Wishbone master rules, decode stall stability and redirect flush

`timescale 1ns/1ps

module if_stage_sva (
        input logic                  clk,
        input logic                  rst_i,
        input logic                  pc_set_i,
        input logic                  wb_cyc_o,
        input logic                  wb_stb_o,
        input if_addr_pkg::addr_t    wb_adr_o,
        input logic                  wb_ack_i,
        input logic                  wb_err_i,
        input logic                  id_valid_o,
        input if_instr_pkg::id_out_t id_o,
        input logic                  id_ready_i
);

        // Number of failed properties
        int fail_count = 0;

        stb_needs_cyc: assert property (@(posedge clk) disable iff (rst_i)
                wb_stb_o |-> wb_cyc_o)
                else begin
                        fail_count++;
                        $error("wb_stb_o high without wb_cyc_o");
                end

        // Open bus cycle keeps its address until ack or err
        adr_held: assert property (@(posedge clk) disable iff (rst_i)
                wb_cyc_o && !wb_ack_i && !wb_err_i |=> wb_cyc_o && $stable(wb_adr_o))
                else begin
                        fail_count++;
                        $error("bus cycle dropped or wb_adr_o changed before ack");
                end

        id_held: assert property (@(posedge clk) disable iff (rst_i)
                id_valid_o && !id_ready_i |=> $stable(id_o))
                else begin
                        fail_count++;
                        $error("id_o changed while decode stalled");
                end

        flush_on_set: assert property (@(posedge clk) disable iff (rst_i)
                pc_set_i |=> !id_valid_o)
                else begin
                        fail_count++;
                        $error("id_valid_o high in the cycle after pc_set_i");
                end

endmodule

bind if_stage if_stage_sva i_if_stage_sva (
        .clk        (clk),
        .rst_i      (rst_i),
        .pc_set_i   (pc_set_i),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_adr_o   (wb_adr_o),
        .wb_ack_i   (wb_ack_i),
        .wb_err_i   (wb_err_i),
        .id_valid_o (id_valid_o),
        .id_o       (id_o),
        .id_ready_i (id_ready_i)
);

//--- tests/tb_if_stage.sv
// Testbench for the instruction fetch stage
// Wishbone memory model, random decode stalls and a reference walk
// of the memory image for five redirect segments

`timescale 1ns/1ps

module tb_if_stage;

        localparam int                      MEM_WORDS  = 1024;
        localparam int                      MAX_CYCLES = 4000;
        localparam if_addr_pkg::addr_t      BOOT_ADDR  = 32'h0000_0100;
        localparam if_addr_pkg::addr_t      JUMP_ADDR  = 32'h0000_0302;
        localparam if_addr_pkg::addr_t      MEPC_ADDR  = 32'h0000_0782;
        localparam if_addr_pkg::addr_t      DEPC_ADDR  = 32'h0000_0906;
        localparam if_addr_pkg::trap_base_t TRAP_BASE  = 24'h00_0005;
        // Word at 0x920 answers with wb_err_i
        localparam logic [9:0]              ERR_IDX    = 10'h248;

        logic                    clk;
        logic                    rst_i;
        logic                    pc_set_i;
        if_addr_pkg::pc_src_e    pc_mux_i;
        if_addr_pkg::exc_mode_e  exc_mode_i;
        if_addr_pkg::addr_t      boot_addr_i;
        if_addr_pkg::addr_t      jump_target_i;
        if_addr_pkg::addr_t      mepc_i;
        if_addr_pkg::addr_t      depc_i;
        if_addr_pkg::trap_base_t trap_base_i;
        if_addr_pkg::cause_t     irq_cause_i;
        logic                    is_irq_i;
        logic                    csr_mtvec_init_o;
        logic                    wb_cyc_o;
        logic                    wb_stb_o;
        if_addr_pkg::addr_t      wb_adr_o;
        if_instr_pkg::instr_t    wb_dat_i;
        logic                    wb_ack_i;
        logic                    wb_err_i;
        logic                    id_valid_o;
        if_instr_pkg::id_out_t   id_o;
        logic                    id_ready_i;
        logic                    if_busy_o;

        if_instr_pkg::instr_t    mem [MEM_WORDS];
        if_instr_pkg::id_out_t   exp_q [$];
        if_instr_pkg::id_out_t   exp;
        logic [31:0]             lfsr = 32'hd7f0;
        int                      wait_left = 0;
        int                      accepted = 0;
        int                      target = 0;
        int                      errors = 0;
        int                      cycles = 0;
        int                      mtvec_pulses = 0;
        logic                    stall_en = 1'b0;
        if_addr_pkg::cause_t     cause;

        if_stage i_dut (.*);

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Galois LFSR, one step per bit taken
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        r    = {r[30:0], lfsr[0]};
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
                end
                return r;
        endfunction

        function automatic void fill_memory();
                if_instr_pkg::instr_t w;
                for (int i = 0; i < MEM_WORDS; i++) begin
                        w = rand_bits(32);
                        // About half the parcels compressed, the rest 32-bit
                        w[1:0]   = rand_bits(1) ? {1'b0, w[0]} : 2'b11;
                        w[17:16] = rand_bits(1) ? {1'b0, w[16]} : 2'b11;
                        mem[i]   = w;
                end
        endfunction

        function automatic if_instr_pkg::parcel_t half_at(input if_addr_pkg::addr_t a);
                if_instr_pkg::instr_t w;
                w = mem[a[11:2]];
                return a[1] ? w[31:16] : w[15:0];
        endfunction

        function automatic logic err_at(input if_addr_pkg::addr_t a);
                return (a[11:2] == ERR_IDX);
        endfunction

        // --------------------
        // Reference model
        // --------------------
        function automatic if_instr_pkg::id_out_t ref_instr(input if_addr_pkg::addr_t pc);
                if_instr_pkg::id_out_t r;
                if_instr_pkg::parcel_t p;
                p    = half_at(pc);
                r.pc = pc;
                if (p[1:0] != 2'b11) begin
                        r.instr         = {16'h0000, p};
                        r.is_compressed = 1'b1;
                        r.fetch_err     = err_at(pc);
                end else begin
                        r.instr         = {half_at(pc + 2), p};
                        r.is_compressed = 1'b0;
                        r.fetch_err     = err_at(pc) | err_at(pc + 2);
                end
                return r;
        endfunction

        function automatic void build_expected(input if_addr_pkg::addr_t start, input int n);
                if_addr_pkg::addr_t    pc;
                if_instr_pkg::id_out_t e;
                exp_q.delete();
                pc = start;
                for (int i = 0; i < n; i++) begin
                        e = ref_instr(pc);
                        exp_q.push_back(e);
                        pc = pc + (e.is_compressed ? 2 : 4);
                end
        endfunction

        // --------------------
        // Per-cycle stimulus
        // --------------------
        task automatic bus_step();
                if (wb_ack_i || wb_err_i) begin
                        wb_ack_i = 1'b0;
                        wb_err_i = 1'b0;
                end else if (wb_cyc_o && wb_stb_o) begin
                        if (wait_left == 0) begin
                                wb_dat_i  = mem[wb_adr_o[11:2]];
                                wb_err_i  = (wb_adr_o[11:2] == ERR_IDX);
                                wb_ack_i  = ~wb_err_i;
                                wait_left = rand_bits(2);
                        end else begin
                                wait_left--;
                        end
                end
        endtask

        task automatic cycle_step(input logic redirect);
                bus_step();
                pc_set_i = redirect;
                if (redirect) begin
                        id_ready_i = 1'b0;
                end else if (!stall_en) begin
                        id_ready_i = 1'b1;
                end else begin
                        id_ready_i = (rand_bits(2) != 0);
                end
        endtask

        task automatic start_segment(input if_addr_pkg::addr_t start);
                int len;
                len = 48 + rand_bits(4);
                build_expected(start, len);
                target = accepted + len;
        endtask

        task automatic wait_segment();
                while (accepted < target) begin
                        cycle_step(1'b0);
                        @(negedge clk);
                end
        endtask

        task automatic redirect_to(input if_addr_pkg::pc_src_e src,
                                   input if_addr_pkg::addr_t   start);
                pc_mux_i = src;
                start_segment(start);
                cycle_step(1'b1);
                @(negedge clk);
        endtask

        initial begin
                rst_i         = 1'b1;
                pc_set_i      = 1'b0;
                pc_mux_i      = if_addr_pkg::PC_BOOT;
                exc_mode_i    = if_addr_pkg::EXC_DIRECT;
                boot_addr_i   = BOOT_ADDR;
                jump_target_i = JUMP_ADDR;
                mepc_i        = MEPC_ADDR;
                depc_i        = DEPC_ADDR;
                trap_base_i   = TRAP_BASE;
                irq_cause_i   = '0;
                is_irq_i      = 1'b0;
                wb_dat_i      = '0;
                wb_ack_i      = 1'b0;
                wb_err_i      = 1'b0;
                id_ready_i    = 1'b0;
                fill_memory();
                repeat (2) @(negedge clk);

                // All control outputs low while reset holds
                assert (!wb_cyc_o && !wb_stb_o && !id_valid_o && !csr_mtvec_init_o &&
                        !if_busy_o) else begin
                        errors++;
                        $display("[FAIL] in reset wb_cyc_o %h wb_stb_o %h id_valid_o %h",
                                 wb_cyc_o, wb_stb_o, id_valid_o);
                        $display("[FAIL] in reset csr_mtvec_init_o %h if_busy_o %h",
                                 csr_mtvec_init_o, if_busy_o);
                end
                rst_i = 1'b0;

                // Boot stream with decode always ready
                start_segment(BOOT_ADDR);
                wait_segment();
                stall_en = 1'b1;
                redirect_to(if_addr_pkg::PC_JUMP, JUMP_ADDR);
                wait_segment();

                // Nonzero cause so the vectored offset shows
                cause       = if_addr_pkg::cause_t'(1 + rand_bits(4));
                exc_mode_i  = if_addr_pkg::EXC_VECTORED;
                is_irq_i    = 1'b1;
                irq_cause_i = cause;
                redirect_to(if_addr_pkg::PC_EXC,
                            if_addr_pkg::addr_t'(TRAP_BASE) * 256 +
                            if_addr_pkg::addr_t'(cause) * 4);
                wait_segment();
                redirect_to(if_addr_pkg::PC_MRET, MEPC_ADDR);
                wait_segment();
                redirect_to(if_addr_pkg::PC_DRET, DEPC_ADDR);
                wait_segment();
                id_ready_i = 1'b0;

                assert (mtvec_pulses == 1) else begin
                        errors++;
                        $display("[FAIL] csr_mtvec_init_o pulses %h expected %h", mtvec_pulses, 1);
                end
                errors += i_dut.i_if_stage_sva.fail_count;
                $display("Checked %0d instructions, %0d errors", accepted, errors);
                if (errors == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

        // --------------------
        // Comparison
        // --------------------
        always @(posedge clk) begin
                if (!rst_i && csr_mtvec_init_o) begin
                        mtvec_pulses++;
                end
                if (!rst_i && wb_cyc_o) begin
                        assert (if_busy_o) else begin
                                errors++;
                                $display("[FAIL] if_busy_o %h expected %h with wb_cyc_o high",
                                         if_busy_o, 1'b1);
                        end
                end
                if (!rst_i && id_valid_o && id_ready_i) begin
                        accepted++;
                        assert (exp_q.size() != 0) else begin
                                errors++;
                                $display("Decode accepted pc %h but no instruction was expected",
                                         id_o.pc);
                        end
                        if (exp_q.size() != 0) begin
                                exp = exp_q.pop_front();
                                assert (id_o == exp) else begin
                                        errors++;
                                        $display("[FAIL] id_o pc %h instr %h c %h err %h",
                                                 id_o.pc, id_o.instr, id_o.is_compressed,
                                                 id_o.fetch_err);
                                        $display("[FAIL]   expected pc %h instr %h c %h err %h",
                                                 exp.pc, exp.instr, exp.is_compressed,
                                                 exp.fetch_err);
                                end
                        end
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout after %0d cycles, the instruction stream stalled",
                                 cycles);
                        $display("Checked %0d instructions, %0d errors", accepted, errors);
                        $display("ERRORS FOUND");
                        $finish;
                end
        end

endmodule

//--- sources.f
+incdir+verilog
verilog/if_addr_pkg.sv
verilog/if_instr_pkg.sv
verilog/pc_select.sv
verilog/prefetch_fifo.sv
verilog/fetch_aligner.sv
verilog/if_stage.sv
tests/if_stage_sva.sv
tests/tb_if_stage.sv
